// ==== hdl/texture_pkg.sv ====
package texture_pkg;

	// --------------------------------------------------
	// sampler geometry
	// --------------------------------------------------
	localparam int SAMPLER_NUM       = 2;
	localparam int COMPONENT_NUM     = 3;
	localparam int DATA_WIDTH        = 8;
	localparam int TEXEL_WIDTH       = COMPONENT_NUM * DATA_WIDTH;
	localparam int X_INT_WIDTH       = 8;
	localparam int Y_INT_WIDTH       = 8;
	localparam int X_FRAC_WIDTH      = 4;
	localparam int Y_FRAC_WIDTH      = 4;
	localparam int COORD_WIDTH       = X_INT_WIDTH + X_FRAC_WIDTH;

	// one extra bit so that x0+1 never wraps
	localparam int FETCH_COORD_WIDTH = X_INT_WIDTH + 1;

	// weight 0..256
	localparam int COEFF_WIDTH       = 9;
	localparam int USER_WIDTH        = 8;

	localparam logic [TEXEL_WIDTH-1:0] BORDER_TEXEL = '0;

endpackage

// ==== hdl/mem_pkg.sv ====
package mem_pkg;

	// read port
	localparam int ADDR_WIDTH   = 32;
	localparam int WORD_WIDTH   = 32;

	// direct mapped line cache, 4 texels per line
	localparam int LINE_WORDS   = 4;
	localparam int LINE_NUM     = 16;
	localparam int INDEX_WIDTH  = 4;
	localparam int TAG_WIDTH    = 10;

	// stride in texels
	localparam int STRIDE_WIDTH = 16;

endpackage

// ==== hdl/texture_bilinear_unit.sv ====
`timescale 1ns/1ns

module texture_bilinear_unit (
	input  logic                                      clk,
	input  logic                                      reset,

	input  logic [texture_pkg::COORD_WIDTH-1:0]       s_x,
	input  logic [texture_pkg::COORD_WIDTH-1:0]       s_y,
	input  logic [texture_pkg::USER_WIDTH-1:0]        s_user,
	input  logic                                      s_valid,
	output logic                                      s_ready,

	output logic [texture_pkg::TEXEL_WIDTH-1:0]       m_data,
	output logic [texture_pkg::USER_WIDTH-1:0]        m_user,
	output logic                                      m_valid,
	input  logic                                      m_ready,

	output logic [texture_pkg::FETCH_COORD_WIDTH-1:0] fetch_x,
	output logic [texture_pkg::FETCH_COORD_WIDTH-1:0] fetch_y,
	output logic [texture_pkg::COEFF_WIDTH-1:0]       fetch_coeff,
	output logic                                      fetch_valid,
	input  logic                                      fetch_ready,

	input  logic [texture_pkg::TEXEL_WIDTH-1:0]       texel_data,
	input  logic [texture_pkg::COEFF_WIDTH-1:0]       texel_coeff,
	input  logic                                      texel_valid,
	output logic                                      texel_ready
);

	// --------------------------------------------------
	// issue side
	// --------------------------------------------------
	logic                                  issue_busy;
	logic [1:0]                            issue_cnt;
	logic [texture_pkg::X_INT_WIDTH-1:0]   x0;
	logic [texture_pkg::Y_INT_WIDTH-1:0]   y0;
	logic [texture_pkg::X_FRAC_WIDTH:0]    fx;
	logic [texture_pkg::Y_FRAC_WIDTH:0]    fy;
	logic [texture_pkg::X_FRAC_WIDTH:0]    wx;
	logic [texture_pkg::Y_FRAC_WIDTH:0]    wy;

	// user tag fifo, depth 4
	logic [texture_pkg::USER_WIDTH-1:0]    fifo_mem [4];
	logic [2:0]                            wr_ptr;
	logic [2:0]                            rd_ptr;
	logic                                  fifo_full;

	assign fifo_full = (wr_ptr[2] != rd_ptr[2]) && (wr_ptr[1:0] == rd_ptr[1:0]);
	assign s_ready   = !issue_busy && !fifo_full;

	// corner order: bit 0 steps x, bit 1 steps y
	assign wx = issue_cnt[0] ? fx : ({1'b1, {texture_pkg::X_FRAC_WIDTH{1'b0}}} - fx);
	assign wy = issue_cnt[1] ? fy : ({1'b1, {texture_pkg::Y_FRAC_WIDTH{1'b0}}} - fy);

	assign fetch_x     = {1'b0, x0} + issue_cnt[0];
	assign fetch_y     = {1'b0, y0} + issue_cnt[1];
	assign fetch_coeff = wx * wy;
	assign fetch_valid = issue_busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			issue_busy <= 1'b0;
			issue_cnt  <= '0;
			wr_ptr     <= '0;
		end else if (s_valid && s_ready) begin
			issue_busy <= 1'b1;
			issue_cnt  <= '0;
			wr_ptr     <= wr_ptr + 3'd1;
		end else if (fetch_valid && fetch_ready) begin
			issue_cnt <= issue_cnt + 2'd1;
			if (issue_cnt == 2'd3)
				issue_busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (s_valid && s_ready) begin
			x0                    <= s_x[texture_pkg::COORD_WIDTH-1 -: texture_pkg::X_INT_WIDTH];
			y0                    <= s_y[texture_pkg::COORD_WIDTH-1 -: texture_pkg::Y_INT_WIDTH];
			fx                    <= {1'b0, s_x[texture_pkg::X_FRAC_WIDTH-1:0]};
			fy                    <= {1'b0, s_y[texture_pkg::Y_FRAC_WIDTH-1:0]};
			fifo_mem[wr_ptr[1:0]] <= s_user;
		end
	end

	// --------------------------------------------------
	// accumulate side
	// --------------------------------------------------
	logic [1:0] texel_cnt;
	logic [texture_pkg::DATA_WIDTH+texture_pkg::COEFF_WIDTH-1:0]
		acc [texture_pkg::COMPONENT_NUM];
	logic [texture_pkg::DATA_WIDTH+texture_pkg::COEFF_WIDTH-1:0]
		acc_next [texture_pkg::COMPONENT_NUM];
	logic [texture_pkg::DATA_WIDTH+texture_pkg::COEFF_WIDTH-1:0]
		rounded [texture_pkg::COMPONENT_NUM];

	// output register must be free before the next texel is taken
	assign texel_ready = !m_valid;
	assign m_user      = fifo_mem[rd_ptr[1:0]];

	always_comb begin
		for (int c = 0; c < texture_pkg::COMPONENT_NUM; c++) begin
			acc_next[c] = acc[c]
				+ texel_coeff * texel_data[c*texture_pkg::DATA_WIDTH +: texture_pkg::DATA_WIDTH];
			// half lsb of the 8 bit weight scale
			rounded[c]  = acc_next[c]
				+ (1 << (texture_pkg::X_FRAC_WIDTH + texture_pkg::Y_FRAC_WIDTH - 1));
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			texel_cnt <= '0;
			m_valid   <= 1'b0;
			rd_ptr    <= '0;
			for (int c = 0; c < texture_pkg::COMPONENT_NUM; c++)
				acc[c] <= '0;
		end else begin
			if (m_valid && m_ready) begin
				m_valid <= 1'b0;
				rd_ptr  <= rd_ptr + 3'd1;
			end
			if (texel_valid && texel_ready) begin
				texel_cnt <= texel_cnt + 2'd1;
				for (int c = 0; c < texture_pkg::COMPONENT_NUM; c++)
					acc[c] <= (texel_cnt == 2'd3) ? '0 : acc_next[c];
				if (texel_cnt == 2'd3)
					m_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (texel_valid && texel_ready && texel_cnt == 2'd3) begin
			for (int c = 0; c < texture_pkg::COMPONENT_NUM; c++)
				m_data[c*texture_pkg::DATA_WIDTH +: texture_pkg::DATA_WIDTH] <=
					rounded[c][texture_pkg::X_FRAC_WIDTH+texture_pkg::Y_FRAC_WIDTH +:
						texture_pkg::DATA_WIDTH];
		end
	end

endmodule

// ==== hdl/texture_cache_core.sv ====
`timescale 1ns/1ns

module texture_cache_core (
	input  logic                                          clk,
	input  logic                                          reset,

	input  logic [mem_pkg::ADDR_WIDTH-1:0]                param_addr,
	input  logic [texture_pkg::FETCH_COORD_WIDTH-1:0]     param_width,
	input  logic [texture_pkg::FETCH_COORD_WIDTH-1:0]     param_height,
	input  logic [mem_pkg::STRIDE_WIDTH-1:0]              param_stride,

	input  logic                                          clear_start,
	output logic                                          clear_busy,
	output logic                                          status_hit,
	output logic                                          status_miss,
	output logic                                          status_range_out,

	input  logic [texture_pkg::SAMPLER_NUM*texture_pkg::FETCH_COORD_WIDTH-1:0] fetch_x,
	input  logic [texture_pkg::SAMPLER_NUM*texture_pkg::FETCH_COORD_WIDTH-1:0] fetch_y,
	input  logic [texture_pkg::SAMPLER_NUM*texture_pkg::COEFF_WIDTH-1:0]       fetch_coeff,
	input  logic [texture_pkg::SAMPLER_NUM-1:0]                                fetch_valid,
	output logic [texture_pkg::SAMPLER_NUM-1:0]                                fetch_ready,

	output logic [texture_pkg::SAMPLER_NUM*texture_pkg::TEXEL_WIDTH-1:0]       texel_data,
	output logic [texture_pkg::SAMPLER_NUM*texture_pkg::COEFF_WIDTH-1:0]       texel_coeff,
	output logic [texture_pkg::SAMPLER_NUM-1:0]                                texel_valid,
	input  logic [texture_pkg::SAMPLER_NUM-1:0]                                texel_ready,

	output logic [mem_pkg::ADDR_WIDTH-1:0]                mem_araddr,
	output logic                                          mem_arvalid,
	input  logic                                          mem_arready,
	input  logic [mem_pkg::WORD_WIDTH-1:0]                mem_rdata,
	input  logic                                          mem_rlast,
	input  logic                                          mem_rvalid,
	output logic                                          mem_rready
);

	logic [$clog2(texture_pkg::SAMPLER_NUM)-1:0]   grant;
	logic [$clog2(texture_pkg::SAMPLER_NUM)-1:0]   last_port;
	logic [$clog2(texture_pkg::SAMPLER_NUM)-1:0]   req_port;
	logic                                          grant_valid;
	logic                                          accept;
	logic                                          busy;
	logic                                          resp_valid;

	logic [texture_pkg::FETCH_COORD_WIDTH-1:0]     gx;
	logic [texture_pkg::FETCH_COORD_WIDTH-1:0]     gy;
	logic                                          in_range;
	logic                                          hit;
	logic [mem_pkg::INDEX_WIDTH-1:0]               index;
	logic [mem_pkg::TAG_WIDTH-1:0]                 tag;
	logic [$clog2(mem_pkg::LINE_WORDS)-1:0]        word;
	logic [mem_pkg::ADDR_WIDTH-1:0]                line_addr;

	logic [mem_pkg::INDEX_WIDTH-1:0]               req_index;
	logic [mem_pkg::TAG_WIDTH-1:0]                 req_tag;
	logic [$clog2(mem_pkg::LINE_WORDS)-1:0]        req_word;
	logic [texture_pkg::COEFF_WIDTH-1:0]           req_coeff;
	logic [texture_pkg::TEXEL_WIDTH-1:0]           resp_data;
	logic [$clog2(mem_pkg::LINE_WORDS)-1:0]        fill_cnt;
	logic [mem_pkg::INDEX_WIDTH-1:0]               clear_cnt;

	logic [mem_pkg::LINE_NUM-1:0]                  tag_valid;
	logic [mem_pkg::TAG_WIDTH-1:0]                 tag_mem [mem_pkg::LINE_NUM];
	logic [texture_pkg::TEXEL_WIDTH-1:0]
		line_mem [mem_pkg::LINE_NUM*mem_pkg::LINE_WORDS];

	// --------------------------------------------------
	// round robin arbiter
	// --------------------------------------------------
	always_comb begin
		int idx;
		grant       = last_port;
		grant_valid = 1'b0;
		// start with the port after the last winner
		for (int k = 1; k <= texture_pkg::SAMPLER_NUM; k++) begin
			idx = (int'(last_port) + k) % texture_pkg::SAMPLER_NUM;
			if (!grant_valid && fetch_valid[idx]) begin
				grant       = idx[$clog2(texture_pkg::SAMPLER_NUM)-1:0];
				grant_valid = 1'b1;
			end
		end
	end

	assign busy   = mem_arvalid || mem_rready || resp_valid;
	assign accept = grant_valid && !busy && !clear_busy;

	always_comb begin
		fetch_ready        = '0;
		fetch_ready[grant] = accept;
		texel_valid           = '0;
		texel_valid[req_port] = resp_valid;
	end

	// every port sees the same word, valid selects the owner
	assign texel_data  = {texture_pkg::SAMPLER_NUM{resp_data}};
	assign texel_coeff = {texture_pkg::SAMPLER_NUM{req_coeff}};

	// --------------------------------------------------
	// lookup
	// --------------------------------------------------
	assign gx       = fetch_x[grant*texture_pkg::FETCH_COORD_WIDTH +: texture_pkg::FETCH_COORD_WIDTH];
	assign gy       = fetch_y[grant*texture_pkg::FETCH_COORD_WIDTH +: texture_pkg::FETCH_COORD_WIDTH];
	assign in_range = (gx < param_width) && (gy < param_height);

	// index is y[1:0] over x[3:2], tag is the rest
	assign index = {gy[1:0], gx[3:2]};
	assign tag   = {gy[texture_pkg::Y_INT_WIDTH-1:2], gx[texture_pkg::X_INT_WIDTH-1:4]};
	assign word  = gx[1:0];
	assign hit   = tag_valid[index] && (tag_mem[index] == tag);

	// byte address of the first texel in the line
	assign line_addr = param_addr + ((gy * param_stride + {gx[texture_pkg::X_INT_WIDTH:2], 2'b00}) << 2);

	// --------------------------------------------------
	// control
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			mem_arvalid      <= 1'b0;
			mem_rready       <= 1'b0;
			resp_valid       <= 1'b0;
			last_port        <= '0;
			fill_cnt         <= '0;
			status_hit       <= 1'b0;
			status_miss      <= 1'b0;
			status_range_out <= 1'b0;
		end else begin
			status_hit       <= accept && in_range && hit;
			status_miss      <= accept && in_range && !hit;
			status_range_out <= accept && !in_range;
			if (accept) begin
				last_port <= grant;
				fill_cnt  <= '0;
				if (in_range && !hit)
					mem_arvalid <= 1'b1;
				else
					resp_valid <= 1'b1;
			end
			if (mem_arvalid && mem_arready) begin
				mem_arvalid <= 1'b0;
				mem_rready  <= 1'b1;
			end
			if (mem_rvalid && mem_rready) begin
				fill_cnt <= fill_cnt + 1'b1;
				if (mem_rlast) begin
					mem_rready <= 1'b0;
					resp_valid <= 1'b1;
				end
			end
			if (resp_valid && texel_ready[req_port])
				resp_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_port   <= grant;
			req_coeff  <= fetch_coeff[grant*texture_pkg::COEFF_WIDTH +: texture_pkg::COEFF_WIDTH];
			req_index  <= index;
			req_tag    <= tag;
			req_word   <= word;
			mem_araddr <= line_addr;
			resp_data  <= in_range ? line_mem[{index, word}] : texture_pkg::BORDER_TEXEL;
		end
		if (mem_rvalid && mem_rready) begin
			line_mem[{req_index, fill_cnt}] <= mem_rdata[texture_pkg::TEXEL_WIDTH-1:0];
			if (fill_cnt == req_word)
				resp_data <= mem_rdata[texture_pkg::TEXEL_WIDTH-1:0];
			if (mem_rlast)
				tag_mem[req_index] <= req_tag;
		end
	end

	// --------------------------------------------------
	// valid bits and clear sweep
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			tag_valid  <= '0;
			clear_busy <= 1'b0;
			clear_cnt  <= '0;
		end else begin
			if (mem_rvalid && mem_rready && mem_rlast)
				tag_valid[req_index] <= 1'b1;
			if (clear_busy) begin
				tag_valid[clear_cnt] <= 1'b0;
				clear_cnt            <= clear_cnt + 1'b1;
				if (&clear_cnt)
					clear_busy <= 1'b0;
			end else if (clear_start) begin
				clear_busy <= 1'b1;
				clear_cnt  <= '0;
			end
		end
	end

endmodule

// ==== hdl/texture_sampler.sv ====
`timescale 1ns/1ns

module texture_sampler (
	input  logic                                          clk,
	input  logic                                          reset,

	input  logic [mem_pkg::ADDR_WIDTH-1:0]                param_addr,
	input  logic [texture_pkg::FETCH_COORD_WIDTH-1:0]     param_width,
	input  logic [texture_pkg::FETCH_COORD_WIDTH-1:0]     param_height,
	input  logic [mem_pkg::STRIDE_WIDTH-1:0]              param_stride,

	input  logic                                          clear_start,
	output logic                                          clear_busy,
	output logic                                          status_hit,
	output logic                                          status_miss,
	output logic                                          status_range_out,

	input  logic [texture_pkg::SAMPLER_NUM*texture_pkg::COORD_WIDTH-1:0] s_sampler_x,
	input  logic [texture_pkg::SAMPLER_NUM*texture_pkg::COORD_WIDTH-1:0] s_sampler_y,
	input  logic [texture_pkg::SAMPLER_NUM*texture_pkg::USER_WIDTH-1:0]  s_sampler_user,
	input  logic [texture_pkg::SAMPLER_NUM-1:0]                          s_sampler_valid,
	output logic [texture_pkg::SAMPLER_NUM-1:0]                          s_sampler_ready,

	output logic [texture_pkg::SAMPLER_NUM*texture_pkg::TEXEL_WIDTH-1:0] m_sampler_data,
	output logic [texture_pkg::SAMPLER_NUM*texture_pkg::USER_WIDTH-1:0]  m_sampler_user,
	output logic [texture_pkg::SAMPLER_NUM-1:0]                          m_sampler_valid,
	input  logic [texture_pkg::SAMPLER_NUM-1:0]                          m_sampler_ready,

	output logic [mem_pkg::ADDR_WIDTH-1:0]                mem_araddr,
	output logic                                          mem_arvalid,
	input  logic                                          mem_arready,
	input  logic [mem_pkg::WORD_WIDTH-1:0]                mem_rdata,
	input  logic                                          mem_rlast,
	input  logic                                          mem_rvalid,
	output logic                                          mem_rready
);

	localparam int N   = texture_pkg::SAMPLER_NUM;
	localparam int FCW = texture_pkg::FETCH_COORD_WIDTH;
	localparam int CW  = texture_pkg::COEFF_WIDTH;
	localparam int TW  = texture_pkg::TEXEL_WIDTH;
	localparam int XW  = texture_pkg::COORD_WIDTH;
	localparam int UW  = texture_pkg::USER_WIDTH;

	logic [N*FCW-1:0] fetch_x;
	logic [N*FCW-1:0] fetch_y;
	logic [N*CW-1:0]  fetch_coeff;
	logic [N-1:0]     fetch_valid;
	logic [N-1:0]     fetch_ready;
	logic [N*TW-1:0]  texel_data;
	logic [N*CW-1:0]  texel_coeff;
	logic [N-1:0]     texel_valid;
	logic [N-1:0]     texel_ready;

	// --------------------------------------------------
	// bilinear units
	// --------------------------------------------------
	for (genvar i = 0; i < N; i++) begin : g_unit
		texture_bilinear_unit u_unit (
			.clk         (clk),
			.reset       (reset),
			.s_x         (s_sampler_x[i*XW +: XW]),
			.s_y         (s_sampler_y[i*XW +: XW]),
			.s_user      (s_sampler_user[i*UW +: UW]),
			.s_valid     (s_sampler_valid[i]),
			.s_ready     (s_sampler_ready[i]),
			.m_data      (m_sampler_data[i*TW +: TW]),
			.m_user      (m_sampler_user[i*UW +: UW]),
			.m_valid     (m_sampler_valid[i]),
			.m_ready     (m_sampler_ready[i]),
			.fetch_x     (fetch_x[i*FCW +: FCW]),
			.fetch_y     (fetch_y[i*FCW +: FCW]),
			.fetch_coeff (fetch_coeff[i*CW +: CW]),
			.fetch_valid (fetch_valid[i]),
			.fetch_ready (fetch_ready[i]),
			.texel_data  (texel_data[i*TW +: TW]),
			.texel_coeff (texel_coeff[i*CW +: CW]),
			.texel_valid (texel_valid[i]),
			.texel_ready (texel_ready[i])
		);
	end

	// --------------------------------------------------
	// shared cache
	// --------------------------------------------------
	texture_cache_core u_cache (
		.clk              (clk),
		.reset            (reset),
		.param_addr       (param_addr),
		.param_width      (param_width),
		.param_height     (param_height),
		.param_stride     (param_stride),
		.clear_start      (clear_start),
		.clear_busy       (clear_busy),
		.status_hit       (status_hit),
		.status_miss      (status_miss),
		.status_range_out (status_range_out),
		.fetch_x          (fetch_x),
		.fetch_y          (fetch_y),
		.fetch_coeff      (fetch_coeff),
		.fetch_valid      (fetch_valid),
		.fetch_ready      (fetch_ready),
		.texel_data       (texel_data),
		.texel_coeff      (texel_coeff),
		.texel_valid      (texel_valid),
		.texel_ready      (texel_ready),
		.mem_araddr       (mem_araddr),
		.mem_arvalid      (mem_arvalid),
		.mem_arready      (mem_arready),
		.mem_rdata        (mem_rdata),
		.mem_rlast        (mem_rlast),
		.mem_rvalid       (mem_rvalid),
		.mem_rready       (mem_rready)
	);

endmodule

// ==== test/texture_sampler_asserts.sv ====
`timescale 1ns/1ns

module texture_sampler_asserts (
	input logic                                          clk,
	input logic                                          reset,
	input logic                                          clear_busy,
	input logic                                          status_hit,
	input logic                                          status_miss,
	input logic [mem_pkg::ADDR_WIDTH-1:0]                mem_araddr,
	input logic                                          mem_arvalid,
	input logic                                          mem_arready,
	input logic [texture_pkg::SAMPLER_NUM*texture_pkg::TEXEL_WIDTH-1:0] m_sampler_data,
	input logic [texture_pkg::SAMPLER_NUM*texture_pkg::USER_WIDTH-1:0]  m_sampler_user,
	input logic [texture_pkg::SAMPLER_NUM-1:0]           m_sampler_valid,
	input logic [texture_pkg::SAMPLER_NUM-1:0]           m_sampler_ready
);

	localparam int TW = texture_pkg::TEXEL_WIDTH;
	localparam int UW = texture_pkg::USER_WIDTH;

	int fail_count = 0;

	// --------------------------------------------------
	// read address channel
	// --------------------------------------------------
	assert property (@(posedge clk) disable iff (reset)
		mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr))
	else begin
		$error("read address dropped or changed before mem_arready");
		fail_count++;
	end

	// line aligned bursts
	assert property (@(posedge clk) disable iff (reset)
		mem_arvalid |-> mem_araddr[3:0] == 4'h0)
	else begin
		$error("mem_araddr not aligned to 16");
		fail_count++;
	end

	// --------------------------------------------------
	// sample outputs hold under back-pressure
	// --------------------------------------------------
	for (genvar i = 0; i < texture_pkg::SAMPLER_NUM; i++) begin : g_out
		assert property (@(posedge clk) disable iff (reset)
			m_sampler_valid[i] && !m_sampler_ready[i] |=> m_sampler_valid[i]
				&& $stable(m_sampler_data[i*TW +: TW]) && $stable(m_sampler_user[i*UW +: UW]))
		else begin
			$error("sampler output changed while m_sampler_ready was low");
			fail_count++;
		end
	end

	assert property (@(posedge clk) reset |=> !clear_busy)
	else begin
		$error("clear_busy high right after reset");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (reset) !(status_hit && status_miss))
	else begin
		$error("status_hit and status_miss high together");
		fail_count++;
	end

endmodule

bind texture_sampler texture_sampler_asserts u_asserts (.*);

// ==== test/tb_texture_sampler.sv ====
`timescale 1ns/1ns

module tb_texture_sampler;

	localparam logic [31:0] BASE = 32'h0002_0000;
	localparam int IMG_W       = 37;
	localparam int IMG_H       = 29;
	localparam int STRIDE      = 48;
	localparam int CYCLE_LIMIT = 20000;

	logic        clk = 1'b0;
	logic        reset;
	logic        clear_start;
	logic        clear_busy;
	logic        status_hit;
	logic        status_miss;
	logic        status_range_out;
	logic [23:0] s_sampler_x;
	logic [23:0] s_sampler_y;
	logic [15:0] s_sampler_user;
	logic [1:0]  s_sampler_valid;
	logic [1:0]  s_sampler_ready;
	logic [47:0] m_sampler_data;
	logic [15:0] m_sampler_user;
	logic [1:0]  m_sampler_valid;
	logic [1:0]  m_sampler_ready = '0;
	logic [31:0] mem_araddr;
	logic        mem_arvalid;
	logic        mem_arready = 1'b0;
	logic [31:0] mem_rdata = '0;
	logic        mem_rlast = 1'b0;
	logic        mem_rvalid = 1'b0;
	logic        mem_rready;

	integer      seed = 32'hbf87;
	int          errors = 0;
	int          checks = 0;
	int          mark_errors = 0;
	int          mark_checks = 0;
	int          cycles = 0;
	int          hits = 0;
	int          misses = 0;
	int          ranges = 0;
	int          bursts = 0;
	bit          backpressure = 1'b0;
	// {user, texel} per sampler, in request order
	logic [31:0] expected [2][$];

	texture_sampler DUT (
		.param_addr   (BASE),
		.param_width  (9'(IMG_W)),
		.param_height (9'(IMG_H)),
		.param_stride (16'(STRIDE)),
		.*
	);

	always #20 clk = ~clk;

	// --------------------------------------------------
	// image pattern and reference model
	// --------------------------------------------------
	function automatic logic [7:0] pattern(int x, int y, int c);
		case (c)
			0:       return 8'((7 * x + y) % 256);
			1:       return 8'(x ^ (3 * y));
			default: return 8'((x + 5 * y) % 256);
		endcase
	endfunction

	function automatic logic [31:0] mem_word(logic [31:0] addr);
		int t;
		int x;
		int y;
		t = int'((addr - BASE) >> 2);
		x = t % STRIDE;
		y = t / STRIDE;
		return {8'h00, pattern(x, y, 2), pattern(x, y, 1), pattern(x, y, 0)};
	endfunction

	// corners outside the image read as border
	function automatic logic [7:0] corner(int x, int y, int c);
		if (x >= IMG_W || y >= IMG_H)
			return 8'h00;
		return pattern(x, y, c);
	endfunction

	function automatic logic [31:0] bilinear(int x0, int fx, int y0, int fy, int user);
		int w [4];
		int sum;
		logic [23:0] d;
		w[0] = (16 - fx) * (16 - fy);
		w[1] = fx * (16 - fy);
		w[2] = (16 - fx) * fy;
		w[3] = fx * fy;
		for (int c = 0; c < 3; c++) begin
			sum = 128;
			for (int k = 0; k < 4; k++)
				sum += w[k] * int'(corner(x0 + k % 2, y0 + k / 2, c));
			d[c*8 +: 8] = 8'(sum >> 8);
		end
		return {8'(user), d};
	endfunction

	function automatic int pick(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// --------------------------------------------------
	// memory model, one 4 beat burst at a time
	// --------------------------------------------------
	initial begin : memory_model
		logic [31:0] addr;
		int delay;
		int ar_wait;
		forever begin
			@(negedge clk);
			if (!reset && mem_arvalid) begin
				delay   = 1 + pick(8);
				// arready stalls for part of the burst delay
				ar_wait = pick(delay);
				repeat (ar_wait)
					@(negedge clk);
				addr        = mem_araddr;
				mem_arready = 1'b1;
				@(negedge clk);
				mem_arready = 1'b0;
				bursts++;
				repeat (delay - 1 - ar_wait)
					@(negedge clk);
				for (int b = 0; b < 4; b++) begin
					mem_rdata  = mem_word(addr + 32'(4 * b));
					mem_rlast  = (b == 3);
					mem_rvalid = 1'b1;
					checks++;
					assert (mem_rready)
					else begin
						$display("** Error %0t: mem_rready low during a read beat", $time);
						errors++;
					end
					@(negedge clk);
				end
				mem_rvalid = 1'b0;
				mem_rlast  = 1'b0;
			end
		end
	end

	// ready is chosen first, so the transfer at the next edge is known here
	always @(negedge clk) begin : output_check
		logic [31:0] got;
		logic [31:0] want;
		int rnd;
		for (int p = 0; p < 2; p++) begin
			rnd = $random(seed);
			m_sampler_ready[p] = !reset && (!backpressure || rnd[0]);
			if (m_sampler_valid[p] && m_sampler_ready[p]) begin
				got = {m_sampler_user[p*8 +: 8], m_sampler_data[p*24 +: 24]};
				checks++;
				if (expected[p].size() == 0) begin
					$display("sampler %0d produced an output that was never requested", p);
					errors++;
				end else begin
					want = expected[p].pop_front();
					assert (got == want)
					else begin
						$display("** Error %0t: sampler %0d gave %h, expected %h",
							$time, p, got, want);
						errors++;
					end
				end
			end
		end
	end

	always @(negedge clk) begin
		if (!reset) begin
			hits   += int'(status_hit);
			misses += int'(status_miss);
			ranges += int'(status_range_out);
		end
	end

	initial begin : watchdog
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("run timed out after %0d cycles before all tests finished", cycles);
		$display("SIMULATION FAILED");
		$finish;
	end

	// --------------------------------------------------
	// stimulus helpers
	// --------------------------------------------------
	task automatic check_count(string what, int got, int want);
		checks++;
		assert (got == want)
		else begin
			$display("** Error %0t: %s is %0d, expected %0d", $time, what, got, want);
			errors++;
		end
	endtask

	task automatic report_test(string name);
		$display("test %s: %0d checks, %0d errors", name, checks - mark_checks,
			errors - mark_errors);
		mark_checks = checks;
		mark_errors = errors;
	endtask

	task automatic drive_sample(int p, int x0, int fx, int y0, int fy);
		int user;
		user = pick(256);
		s_sampler_x[p*12 +: 12]  = {x0[7:0], fx[3:0]};
		s_sampler_y[p*12 +: 12]  = {y0[7:0], fy[3:0]};
		s_sampler_user[p*8 +: 8] = user[7:0];
		s_sampler_valid[p]       = 1'b1;
		expected[p].push_back(bilinear(x0, fx, y0, fy, user));
	endtask

	// one sample, then wait until its result came back
	task automatic sample_one(int p, int x0, int fx, int y0, int fy);
		@(negedge clk);
		drive_sample(p, x0, fx, y0, fy);
		while (!s_sampler_ready[p])
			@(negedge clk);
		@(negedge clk);
		s_sampler_valid[p] = 1'b0;
		while (expected[p].size() != 0)
			@(negedge clk);
	endtask

	task automatic outside_sample(int x0, int y0);
		int r;
		r = ranges;
		sample_one(0, x0, pick(16), y0, pick(16));
		check_count("range_out pulses", ranges - r, 4);
	endtask

	// fetches (8,4) (9,4) (8,5) (9,5) touch two lines
	task automatic line_sample_counts(int want_hit, int want_miss, int want_burst);
		int h;
		int m;
		int b;
		h = hits;
		m = misses;
		b = bursts;
		sample_one(0, 8, 0, 4, 0);
		check_count("hit pulses", hits - h, want_hit);
		check_count("miss pulses", misses - m, want_miss);
		check_count("bursts", bursts - b, want_burst);
	endtask

	task automatic run_clear();
		int busy;
		busy = 0;
		@(negedge clk);
		clear_start = 1'b1;
		@(negedge clk);
		clear_start = 1'b0;
		while (clear_busy) begin
			busy++;
			@(negedge clk);
		end
		check_count("clear_busy cycles", busy, mem_pkg::LINE_NUM);
	endtask

	// both samplers stream at once
	task automatic run_dual(int count);
		int sent [2];
		bit took [2];
		sent = '{0, 0};
		took = '{0, 0};
		while (sent[0] < count || sent[1] < count || s_sampler_valid != 2'b00) begin
			@(negedge clk);
			for (int p = 0; p < 2; p++) begin
				if (took[p])
					s_sampler_valid[p] = 1'b0;
				if (!s_sampler_valid[p] && sent[p] < count) begin
					drive_sample(p, pick(IMG_W + 1), pick(16), pick(IMG_H + 1), pick(16));
					sent[p]++;
				end
				took[p] = s_sampler_valid[p] && s_sampler_ready[p];
			end
		end
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin : main
		int total;
		reset           = 1'b1;
		clear_start     = 1'b0;
		s_sampler_x     = '0;
		s_sampler_y     = '0;
		s_sampler_user  = '0;
		s_sampler_valid = '0;
		repeat (3) @(negedge clk);
		reset = 1'b0;

		for (int i = 0; i < 16; i++)
			sample_one(0, pick(IMG_W), 0, pick(IMG_H), 0);
		report_test("integer");

		for (int i = 0; i < 48; i++)
			sample_one(1, pick(IMG_W - 1), pick(16), pick(IMG_H - 1), pick(16));
		report_test("fraction");

		for (int i = 0; i < 8; i++) begin
			sample_one(0, IMG_W - 1, pick(16), pick(IMG_H - 1), pick(16));
			sample_one(1, pick(IMG_W - 1), pick(16), IMG_H - 1, pick(16));
		end
		outside_sample(IMG_W + 3, 2);
		outside_sample(5, IMG_H + 1);
		report_test("border");

		run_clear();
		line_sample_counts(2, 2, 2);
		line_sample_counts(4, 0, 0);
		report_test("hit_miss");

		// lines are gone after the sweep
		run_clear();
		line_sample_counts(2, 2, 2);
		report_test("clear");

		backpressure = 1'b1;
		run_dual(48);
		while (expected[0].size() != 0 || expected[1].size() != 0)
			@(negedge clk);
		backpressure = 1'b0;
		report_test("dual");

		total = errors + DUT.u_asserts.fail_count;
		$display("6 tests, %0d checks, %0d errors", checks, total);
		if (total == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== list.f ====
hdl/texture_pkg.sv
hdl/mem_pkg.sv
hdl/texture_bilinear_unit.sv
hdl/texture_cache_core.sv
hdl/texture_sampler.sv
test/texture_sampler_asserts.sv
test/tb_texture_sampler.sv

// ==== Makefile ====
TOP = tb_texture_sampler

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
		--top-module $(TOP) -f list.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
